//--- source/cart_cmd_pkg.sv
package cart_cmd_pkg;

  //////////////////////////////
  // command opcodes
  //////////////////////////////

  // families are matched on the upper nibble
  localparam logic [7:0] OP_ADDR      = 8'h00;
  localparam logic [7:0] OP_ROM_MASK  = 8'h10;
  localparam logic [7:0] OP_SRAM_MASK = 8'h20;
  localparam logic [7:0] OP_READ      = 8'h80;
  localparam logic [7:0] OP_WRITE     = 8'h90;

  // full-byte commands
  localparam logic [7:0] OP_FEATURE   = 8'hED;
  localparam logic [7:0] OP_REGION    = 8'hEE;
  localparam logic [7:0] OP_ECHO      = 8'hF0;
  localparam logic [7:0] OP_STATUS    = 8'hF1;
  localparam logic [7:0] OP_LOOPBACK  = 8'hFF;

  // read/write opcode bit for address auto-increment
  localparam int AUTOINC_BIT = 3;

  localparam logic [7:0] ECHO_BYTE = 8'hA5;

  localparam int BYTE_CNT_W = 8;
  localparam int ADDR_MAX_W = 24;

  //////////////////////////////
  // block-to-block bundles
  //////////////////////////////

  typedef struct packed {
    logic [7:0]            cmd;
    logic [7:0]            param;
    logic [BYTE_CNT_W-1:0] byte_cnt;
    logic                  cmd_ready;
    logic                  param_ready;
  } spi_frame_t;

  typedef struct packed {
    logic [ADDR_MAX_W-1:0] addr;
    logic                  write;
    logic [7:0]            wdata;
    logic                  start;
  } mem_rq_t;

  typedef struct packed {
    logic [23:0] rom_mask;
    logic [23:0] saveram_mask;
    logic [7:0]  featurebits;
    logic        region;
  } cart_cfg_t;

endpackage

//--- source/spi_byte_rx.sv
`timescale 1ns/10ps

module spi_byte_rx (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     sck,
  input  logic                     mosi,
  input  logic                     ss_n,
  output logic                     miso,
  input  logic [7:0]               tx_byte,
  output cart_cmd_pkg::spi_frame_t frame
);
  import cart_cmd_pkg::*;

  logic [2:0]            sck_sync;
  logic [1:0]            mosi_sync;
  logic [1:0]            ss_sync;
  logic                  sck_rise;
  logic                  sck_fall;
  logic                  active;
  logic [2:0]            bit_cnt;
  logic [6:0]            rx_shift;
  logic [7:0]            tx_shift;
  logic [BYTE_CNT_W-1:0] byte_idx;
  logic [BYTE_CNT_W-1:0] byte_pos;
  logic [7:0]            cmd_q;
  logic [7:0]            param_q;
  logic                  cmd_rdy_q;
  logic                  param_rdy_q;

  //////////////////////////////
  // pin synchronizers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sck_sync  <= '0;
      mosi_sync <= '0;
      ss_sync   <= 2'b11;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      mosi_sync <= {mosi_sync[0], mosi};
      ss_sync   <= {ss_sync[0], ss_n};
    end
  end

  assign sck_rise = sck_sync[1] & ~sck_sync[2];
  assign sck_fall = ~sck_sync[1] & sck_sync[2];
  assign active   = ~ss_sync[1];

  //////////////////////////////
  // receive side
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt     <= '0;
      byte_idx    <= '0;
      byte_pos    <= '0;
      cmd_q       <= '0;
      cmd_rdy_q   <= 1'b0;
      param_rdy_q <= 1'b0;
    end else begin
      cmd_rdy_q   <= 1'b0;
      param_rdy_q <= 1'b0;
      if (!active) begin
        bit_cnt  <= '0;
        byte_idx <= '0;
        byte_pos <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          byte_pos <= byte_idx;
          byte_idx <= byte_idx + 1'b1;
          // first byte of the frame is the command
          if (byte_idx == '0) begin
            cmd_q     <= {rx_shift, mosi_sync[1]};
            cmd_rdy_q <= 1'b1;
          end else begin
            param_rdy_q <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active && sck_rise) begin
      rx_shift <= {rx_shift[5:0], mosi_sync[1]};
      if (bit_cnt == 3'd7 && byte_idx != '0) begin
        param_q <= {rx_shift, mosi_sync[1]};
      end
    end
  end

  //////////////////////////////
  // transmit side
  //////////////////////////////

  // reply loads after the last falling edge of a byte
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_shift <= '0;
    end else if (!active) begin
      tx_shift <= tx_byte;
    end else if (sck_fall) begin
      tx_shift <= (bit_cnt == 3'd0) ? tx_byte : {tx_shift[6:0], 1'b0};
    end
  end

  assign miso = tx_shift[7];

  assign frame = '{cmd: cmd_q, param: param_q, byte_cnt: byte_pos,
                   cmd_ready: cmd_rdy_q, param_ready: param_rdy_q};

  // frame must close on a byte boundary
  a_frame_whole_bytes : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ss_sync[1]) |-> bit_cnt == 3'd0)
    else $error("ss_n went high in the middle of a byte");

endmodule

//--- source/mcu_cmd.sv
`timescale 1ns/10ps

module mcu_cmd #(
  parameter int ADDR_W = 24
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  cart_cmd_pkg::spi_frame_t frame,
  output cart_cmd_pkg::mem_rq_t    rq,
  input  logic                     rq_done,
  input  logic [7:0]               rq_rdata,
  input  logic                     busy,
  output cart_cmd_pkg::cart_cfg_t  cfg,
  output logic [7:0]               tx_byte
);
  import cart_cmd_pkg::*;

  logic              strobe;
  logic              is_addr;
  logic              is_rom_mask;
  logic              is_sram_mask;
  logic              is_read;
  logic              is_write;
  logic              in_load_range;
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] addr_masked;
  logic              start_q;
  logic              write_q;
  logic [7:0]        wdata_q;
  logic [7:0]        reply_q;

  assign strobe = frame.cmd_ready | frame.param_ready;

  // family decode on the upper nibble
  assign is_addr      = frame.cmd[7:4] == OP_ADDR[7:4];
  assign is_rom_mask  = frame.cmd[7:4] == OP_ROM_MASK[7:4];
  assign is_sram_mask = frame.cmd[7:4] == OP_SRAM_MASK[7:4];
  assign is_read      = frame.cmd[7:4] == OP_READ[7:4];
  assign is_write     = frame.cmd[7:4] == OP_WRITE[7:4];

  // three parameter bytes, high byte first
  assign in_load_range = frame.byte_cnt >= BYTE_CNT_W'(1) &&
                         frame.byte_cnt <= BYTE_CNT_W'(3);

  //////////////////////////////
  // address register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (frame.param_ready && is_addr && in_load_range) begin
      addr_q <= {addr_q[ADDR_W-9:0], frame.param};
    end else if (rq_done && (is_read || is_write) && frame.cmd[AUTOINC_BIT]) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  assign addr_masked = addr_q & cfg.rom_mask[ADDR_W-1:0];

  //////////////////////////////
  // configuration registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg.rom_mask     <= '1;
      cfg.saveram_mask <= '0;
      cfg.featurebits  <= '0;
      cfg.region       <= 1'b0;
    end else if (frame.param_ready) begin
      if (is_rom_mask && in_load_range) begin
        cfg.rom_mask <= {cfg.rom_mask[15:0], frame.param};
      end
      if (is_sram_mask && in_load_range) begin
        cfg.saveram_mask <= {cfg.saveram_mask[15:0], frame.param};
      end
      if (frame.cmd == OP_FEATURE) begin
        cfg.featurebits <= frame.param;
      end
      if (frame.cmd == OP_REGION) begin
        cfg.region <= frame.param[0];
      end
    end
  end

  //////////////////////////////
  // memory requests
  //////////////////////////////

  // reads fetch on every byte, writes only once data is in
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_q <= 1'b0;
      write_q <= 1'b0;
    end else begin
      start_q <= (frame.cmd_ready && is_read) ||
                 (frame.param_ready && (is_read || is_write));
      if (strobe) begin
        write_q <= is_write;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frame.param_ready && is_write) begin
      wdata_q <= frame.param;
    end
  end

  assign rq = '{addr: ADDR_MAX_W'(addr_masked), write: write_q,
                wdata: wdata_q, start: start_q};

  //////////////////////////////
  // reply byte
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reply_q <= '0;
    end else if (rq_done && is_read) begin
      reply_q <= rq_rdata;
    end else if (strobe) begin
      case (frame.cmd)
        OP_ECHO: begin
          if (frame.param_ready) begin
            reply_q <= ECHO_BYTE;
          end
        end
        OP_STATUS: reply_q <= {busy, 6'b0, cfg.region};
        OP_LOOPBACK: begin
          if (frame.param_ready) begin
            reply_q <= frame.param;
          end
        end
        default: ;
      endcase
    end
  end

  assign tx_byte = reply_q;

  // a request must finish within one SPI byte
  a_no_start_busy : assert property (@(posedge clk) disable iff (!rst_n)
    rq.start |-> !busy)
    else $error("memory request started while engine busy");

endmodule

//--- source/mem_rq.sv
`timescale 1ns/10ps

module mem_rq #(
  parameter int ADDR_W = 24
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cart_cmd_pkg::mem_rq_t rq,
  output logic                  mem_req,
  output logic [ADDR_W-1:0]     mem_addr,
  output logic                  mem_write,
  output logic [7:0]            mem_wdata,
  input  logic                  mem_ack,
  input  logic [7:0]            mem_rdata,
  output logic                  rq_done,
  output logic [7:0]            rq_rdata,
  output logic                  busy
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACK_HI,
    ST_ACK_LO
  } state_t;

  state_t state;

  //////////////////////////////
  // four-phase handshake
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      mem_req <= 1'b0;
      rq_done <= 1'b0;
    end else begin
      rq_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (rq.start) begin
            mem_req <= 1'b1;
            state   <= ST_ACK_HI;
          end
        end
        ST_ACK_HI: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state   <= ST_ACK_LO;
          end
        end
        ST_ACK_LO: begin
          // memory released, next request may go
          if (!mem_ack) begin
            rq_done <= 1'b1;
            state   <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // request payload and read data
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && rq.start) begin
      mem_addr  <= rq.addr[ADDR_W-1:0];
      mem_write <= rq.write;
      mem_wdata <= rq.wdata;
    end
    if (state == ST_ACK_HI && mem_ack) begin
      rq_rdata <= mem_rdata;
    end
  end

  assign busy = state != ST_IDLE;

  a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
    mem_req && $past(mem_req) |-> $stable(mem_addr))
    else $error("mem_addr changed during request");

  a_ack_needs_req : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mem_ack) |-> mem_req)
    else $error("mem_ack rose without mem_req");

endmodule

//--- source/cart_cmd_top.sv
`timescale 1ns/10ps

module cart_cmd_top #(
  parameter int ADDR_W = 24
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    sck,
  input  logic                    mosi,
  input  logic                    ss_n,
  output logic                    miso,
  output logic                    mem_req,
  output logic [ADDR_W-1:0]       mem_addr,
  output logic                    mem_write,
  output logic [7:0]              mem_wdata,
  input  logic                    mem_ack,
  input  logic [7:0]              mem_rdata,
  output cart_cmd_pkg::cart_cfg_t cfg
);
  import cart_cmd_pkg::*;

  spi_frame_t frame;
  mem_rq_t    rq;
  logic       rq_done;
  logic [7:0] rq_rdata;
  logic       busy;
  logic [7:0] tx_byte;

  // SPI bytes in, replies out
  spi_byte_rx i_spi_byte_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .sck     (sck),
    .mosi    (mosi),
    .ss_n    (ss_n),
    .miso    (miso),
    .tx_byte (tx_byte),
    .frame   (frame)
  );

  mcu_cmd #(
    .ADDR_W (ADDR_W)
  ) i_mcu_cmd (
    .clk      (clk),
    .rst_n    (rst_n),
    .frame    (frame),
    .rq       (rq),
    .rq_done  (rq_done),
    .rq_rdata (rq_rdata),
    .busy     (busy),
    .cfg      (cfg),
    .tx_byte  (tx_byte)
  );

  // external memory side
  mem_rq #(
    .ADDR_W (ADDR_W)
  ) i_mem_rq (
    .clk       (clk),
    .rst_n     (rst_n),
    .rq        (rq),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_write (mem_write),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .rq_done   (rq_done),
    .rq_rdata  (rq_rdata),
    .busy      (busy)
  );

endmodule

//--- dv/cart_cmd_tb.sv
`timescale 1ns/10ps

module cart_cmd_tb;
  import cart_cmd_pkg::*;

  localparam int    ADDR_W    = 24;
  localparam string DATA_FILE = "dv/cart_cmd_testdata.txt";

  logic              clk;
  logic              rst_n;
  logic              sck;
  logic              mosi;
  logic              ss_n;
  logic              miso;
  logic              mem_req;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_write;
  logic [7:0]        mem_wdata;
  logic              mem_ack;
  logic [7:0]        mem_rdata;
  cart_cfg_t         cfg;

  logic [7:0]        mem [256];
  logic [7:0]        model [256];
  logic [31:0]       exp_wr [$];
  logic [31:0]       seen_wr [$];
  logic [23:0]       last_addr;
  logic [8*160-1:0]  line;
  integer            seed = 36;
  int                fd;
  int                limit = 0;
  int                cycles = 0;
  int                errors = 0;
  int                errs_at_start = 0;
  int                n_pass = 0;
  int                n_fail = 0;
  string             test_name = "";

  cart_cmd_top #(
    .ADDR_W (ADDR_W)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .sck       (sck),
    .mosi      (mosi),
    .ss_n      (ss_n),
    .miso      (miso),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_write (mem_write),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .cfg       (cfg)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // memory responder
  //////////////////////////////

  initial begin
    int delay;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    last_addr = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i]   = $random(seed);
      model[i] = mem[i];
    end
    forever begin
      @(posedge clk);
      #1;
      if (mem_req) begin
        delay = 1 + {$random(seed)} % 8;
        for (int d = 1; d < delay; d++) begin
          @(posedge clk);
          #1;
        end
        last_addr = mem_addr;
        if (mem_write) begin
          mem[mem_addr[7:0]] = mem_wdata;
          seen_wr.push_back({mem_addr, mem_wdata});
        end
        mem_rdata = mem[mem_addr[7:0]];
        mem_ack   = 1'b1;
        while (mem_req) begin
          @(posedge clk);
          #1;
        end
        mem_ack = 1'b0;
      end
    end
  end

  // watchdog
  initial begin
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: no result after %0d clock cycles", limit);
    $display("tests failed");
    $finish;
  end

  //////////////////////////////
  // SPI master and checks
  //////////////////////////////

  task automatic check_value(input string sig, input logic [23:0] exp, input logic [23:0] got);
    assert (got === exp) else begin
      $display("MISMATCH %s expected %h got %h", sig, exp, got);
      errors++;
    end
  endtask

  // mode 0, MSB first; sck stays high after bit 7 so the memory fetch lands
  task automatic xfer(input logic [7:0] tx, output logic [7:0] rx);
    ss_n = 1'b0;
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      repeat (4) @(posedge clk);
      #1;
      rx[i] = miso;
      sck   = 1'b1;
      repeat (i == 0 ? 18 : 4) @(posedge clk);
      #1;
      sck = 1'b0;
    end
  endtask

  task automatic close_frame();
    repeat (4) @(posedge clk);
    #1 ss_n = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (mem_req || mem_ack);
    repeat (4) @(posedge clk);
    #1;
    assert (seen_wr.size() == exp_wr.size()) else begin
      $display("memory saw %0d writes in the frame, expected %0d",
               seen_wr.size(), exp_wr.size());
      errors++;
    end
    for (int i = 0; i < exp_wr.size() && i < seen_wr.size(); i++) begin
      check_value("mem_addr", exp_wr[i][31:8], seen_wr[i][31:8]);
      check_value("mem_wdata", exp_wr[i][7:0], seen_wr[i][7:0]);
    end
    exp_wr.delete();
    seen_wr.delete();
  endtask

  task automatic finish_test();
    if (test_name != "") begin
      if (errors == errs_at_start) begin
        $display("test %s: ok", test_name);
        n_pass++;
      end else begin
        $display("test %s: %0d errors", test_name, errors - errs_at_start);
        n_fail++;
      end
    end
    errs_at_start = errors;
  endtask

  // one pass over the file sizes the watchdog
  task automatic count_bytes();
    string kw;
    int    code;
    int    n_bytes;
    n_bytes = 0;
    while ($fscanf(fd, "%s", kw) == 1) begin
      if (kw[0] == "#") begin
        code = $fgets(line, fd);
      end else if (kw == "tx" || kw == "rx" || kw == "rd" || kw == "wr") begin
        n_bytes++;
      end
    end
    $fclose(fd);
    fd    = $fopen(DATA_FILE, "r");
    limit = n_bytes * 80 + 1000;
  endtask

  task automatic run_tests();
    string       kw;
    string       field;
    int          code;
    logic [7:0]  tx;
    logic [7:0]  rx;
    logic [23:0] val;
    while ($fscanf(fd, "%s", kw) == 1) begin
      if (kw[0] == "#") begin
        code = $fgets(line, fd);
      end else begin
        case (kw)
          "test": begin
            finish_test();
            code = $fscanf(fd, "%s", test_name);
          end
          "tx": begin
            code = $fscanf(fd, "%h", tx);
            xfer(tx, rx);
          end
          "rx": begin
            code = $fscanf(fd, "%h %h", tx, val);
            xfer(tx, rx);
            check_value("miso", val, rx);
          end
          "rd": begin
            code = $fscanf(fd, "%h %h", tx, val);
            xfer(tx, rx);
            check_value("miso", model[val[7:0]], rx);
          end
          "wr": begin
            code = $fscanf(fd, "%h %h", tx, val);
            model[val[7:0]] = tx;
            exp_wr.push_back({val, tx});
            xfer(tx, rx);
          end
          "end": close_frame();
          "check": begin
            code = $fscanf(fd, "%s %h", field, val);
            case (field)
              "rom_mask":     check_value("cfg.rom_mask", val, cfg.rom_mask);
              "saveram_mask": check_value("cfg.saveram_mask", val, cfg.saveram_mask);
              "featurebits":  check_value("cfg.featurebits", val, cfg.featurebits);
              "region":       check_value("cfg.region", val, cfg.region);
              "mem_addr":     check_value("mem_addr", val, last_addr);
              default: begin
                $display("unknown field %s in test data", field);
                errors++;
              end
            endcase
          end
          default: begin
            $display("unknown keyword %s in test data", kw);
            errors++;
          end
        endcase
      end
    end
    finish_test();
  endtask

  initial begin
    rst_n = 1'b0;
    sck   = 1'b0;
    mosi  = 1'b0;
    ss_n  = 1'b1;
    fd    = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("cannot open test data file %s", DATA_FILE);
      $display("tests failed");
    end else begin
      count_bytes();
      repeat (16) @(posedge clk);
      #1 rst_n = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      run_tests();
      $fclose(fd);
      $display("%0d tests run, %0d passed, %0d failed, %0d errors",
               n_pass + n_fail, n_pass, n_fail, errors);
      if (errors == 0) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
    end
    $finish;
  end

endmodule

//--- flist.f
source/cart_cmd_pkg.sv
source/spi_byte_rx.sv
source/mcu_cmd.sv
source/mem_rq.sv
source/cart_cmd_top.sv
dv/cart_cmd_tb.sv

//--- dv/cart_cmd_testdata.txt
# test <name> | check <field> <hex> | tx <byte> | rx <byte> <reply> | end (ss_n high)
# rd <byte> <addr>: reply is memory at addr | wr <byte> <addr>: byte is written at addr
test reset_defaults
check rom_mask ffffff  check saveram_mask 000000
check featurebits 00  check region 0
tx f1  rx 00 00  end
# first reply of a frame is left over from the frame before
test echo
tx f0  tx 11  rx 22 a5  rx 33 a5  end
test loopback
tx ff  tx 3c  rx c3 3c  rx 5a c3  rx 00 5a  end
# burst at 0x000140, written then read back
test write_read_burst
tx 00  tx 00  tx 01  tx 40  end
tx 98  wr de 000140  wr ad 000141  wr be 000142  wr ef 000143  end
tx 00  tx 00  tx 01  tx 40  end
tx 88  rd 00 000140  rd 00 000141  rd 00 000142  rd 00 000143  end
check mem_addr 000144
test read_no_increment
tx 00  tx 00  tx 00  tx 7e  end
tx 80  rd 00 00007e  rd 00 00007e  rd 00 00007e  end
check mem_addr 00007e
test config_regs
tx ed  tx 5a  end
tx 20  tx 12  tx 34  tx 56  end
tx ee  tx 01  end
check featurebits 5a  check saveram_mask 123456  check region 1
tx f1  rx 00 01  end
# 0x000155 masked by 0x00003f lands at 0x000015
test rom_mask
tx 10  tx 00  tx 00  tx 3f  end
check rom_mask 00003f
tx 00  tx 00  tx 01  tx 55  end
tx 80  rd 00 000015  end
check mem_addr 000015
